/* src/debugCmdPkg.sv */
`default_nettype none

package debugCmdPkg;

   ////////////////////////////////////////
   // Host command bytes
   ////////////////////////////////////////
   localparam logic [7:0] cmdContinuous = 8'h63;   // "c"
   localparam logic [7:0] cmdStep       = 8'h73;   // "s"
   localparam logic [7:0] cmdNext       = 8'h6e;   // "n"

   // Controller modes
   typedef enum logic [2:0] {
      INIT       = 3'd0,   // Pipeline cleared once after reset
      IDLE       = 3'd1,
      CONTINUOUS = 3'd2,
      STEP       = 3'd3,
      SEND       = 3'd4    // Dump in progress
   } debugState_t;

endpackage

`default_nettype wire

/* src/debugCommandFsm.sv */
`timescale 1ns/1ps
`default_nettype none

module debugCommandFsm (
   input  logic       clock,
   input  logic       reset,
   input  logic [7:0] rxByte,        // Head of the receive FIFO
   input  logic       rxAvailable,
   input  logic       endOfProgram,
   input  logic       dumpDone,      // From the sequencer, one cycle
   output logic       rxPop,
   output logic       datapathRun,
   output logic       datapathClear,
   output logic       idleLed,
   output logic       memSelect,     // Debug port owns the data memory
   output logic       dumpStart
);

   import debugCmdPkg::*;

   debugState_t state;
   debugState_t nextState;

   logic isNext;   // FIFO head holds a valid n

   assign isNext = rxAvailable && (rxByte == cmdNext);

   ////////////////////////////////////////
   // State register
   ////////////////////////////////////////
   always_ff @(posedge clock) begin
      if (reset) begin
         state     <= INIT;
         dumpStart <= 1'b0;
      end else begin
         state     <= nextState;
         dumpStart <= (state != SEND) && (nextState == SEND);   // First SEND cycle only
      end
   end

   ////////////////////////////////////////
   // Next state and datapath controls
   ////////////////////////////////////////
   always_comb begin
      nextState     = state;
      rxPop         = 1'b0;
      datapathRun   = 1'b0;
      datapathClear = 1'b0;

      case (state)
         INIT: begin
            datapathClear = 1'b1;
            nextState     = IDLE;
         end

         IDLE: begin
            datapathClear = 1'b1;
            rxPop         = rxAvailable;   // Unknown bytes are simply dropped
            if (rxAvailable) begin
               if (rxByte == cmdContinuous) begin
                  nextState     = CONTINUOUS;
                  datapathClear = 1'b0;
               end else if (rxByte == cmdStep) begin
                  nextState     = STEP;
                  datapathClear = 1'b0;
               end
            end
         end

         CONTINUOUS: begin
            datapathRun = 1'b1;
            if (endOfProgram) begin
               nextState = SEND;
            end
         end

         STEP: begin
            rxPop = rxAvailable;
            // One clock of the pipeline per n
            if (isNext) begin
               datapathRun = 1'b1;
               nextState   = SEND;
            end
         end

         SEND: begin
            if (dumpDone) begin
               nextState = endOfProgram ? IDLE : STEP;
            end
         end

         default: begin
            nextState = INIT;
         end
      endcase
   end

   assign idleLed   = (state == IDLE);
   assign memSelect = (state == SEND);

   // FIFO is only popped when it has something to give
   rxPopNeedsData: assert property (
      @(posedge clock) disable iff (reset) rxPop |-> rxAvailable);

   runClearExclusive: assert property (
      @(posedge clock) disable iff (reset) !(datapathRun && datapathClear));

endmodule

`default_nettype wire

/* src/debugUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module debugUnit #(
   parameter int numRegs     = 32,
   parameter int numMemWords = 16,
   localparam int indexWidth = (numRegs > 1) ? $clog2(numRegs) : 1,
   localparam int addrWidth  = (numMemWords > 1) ? $clog2(numMemWords) : 1
) (
   input  logic                                     clock,
   input  logic                                     reset,
   // Receive FIFO
   input  logic [dumpMapPkg::byteWidth-1:0]         rxByte,
   input  logic                                     rxAvailable,
   output logic                                     rxPop,
   // Transmitter
   input  logic                                     txDone,
   output logic                                     txRequest,
   output logic [dumpMapPkg::byteWidth-1:0]         txData,
   // Datapath
   input  logic                                     endOfProgram,
   input  logic [dumpMapPkg::pcWidth-1:0]           pc,
   input  logic [dumpMapPkg::wordWidth-1:0]         instr,
   input  logic [numRegs*dumpMapPkg::wordWidth-1:0] regFile,
   input  logic [dumpMapPkg::wordWidth-1:0]         memData,
   output logic                                     datapathRun,
   output logic                                     datapathClear,
   output logic                                     memSelect,
   output logic [addrWidth-1:0]                     memAddr,
   // Status
   output logic                                     idleLed,
   output logic [dumpMapPkg::byteWidth-1:0]         dumpCount,
   output logic                                     dumpDone
);

   import dumpMapPkg::*;

   logic                  dumpStart;
   dumpSection_t          dumpSection;
   logic [indexWidth-1:0] wordIndex;
   logic [1:0]            byteIndex;

   debugCommandFsm commandFsm (
      .clock         (clock),
      .reset         (reset),
      .rxByte        (rxByte),
      .rxAvailable   (rxAvailable),
      .endOfProgram  (endOfProgram),
      .dumpDone      (dumpDone),
      .rxPop         (rxPop),
      .datapathRun   (datapathRun),
      .datapathClear (datapathClear),
      .idleLed       (idleLed),
      .memSelect     (memSelect),
      .dumpStart     (dumpStart)
   );

   dumpSequencer #(
      .numRegs     (numRegs),
      .numMemWords (numMemWords)
   ) sequencer (
      .clock       (clock),
      .reset       (reset),
      .dumpStart   (dumpStart),
      .txDone      (txDone),
      .txRequest   (txRequest),
      .dumpDone    (dumpDone),
      .dumpCount   (dumpCount),
      .dumpSection (dumpSection),
      .wordIndex   (wordIndex),
      .byteIndex   (byteIndex),
      .memAddr     (memAddr)
   );

   dumpByteSelect #(
      .numRegs (numRegs)
   ) byteSelect (
      .dumpSection (dumpSection),
      .wordIndex   (wordIndex),
      .byteIndex   (byteIndex),
      .pc          (pc),
      .instr       (instr),
      .regFile     (regFile),
      .memData     (memData),
      .txData      (txData)
   );

endmodule

`default_nettype wire

/* src/dumpByteSelect.sv */
`timescale 1ns/1ps
`default_nettype none

module dumpByteSelect #(
   parameter int numRegs     = 32,
   localparam int indexWidth = (numRegs > 1) ? $clog2(numRegs) : 1
) (
   input  dumpMapPkg::dumpSection_t                     dumpSection,
   input  logic [indexWidth-1:0]                        wordIndex,
   input  logic [1:0]                                   byteIndex,
   input  logic [dumpMapPkg::pcWidth-1:0]               pc,
   input  logic [dumpMapPkg::wordWidth-1:0]             instr,
   input  logic [numRegs*dumpMapPkg::wordWidth-1:0]     regFile,   // Register 0 in the low word
   input  logic [dumpMapPkg::wordWidth-1:0]             memData,
   output logic [dumpMapPkg::byteWidth-1:0]             txData
);

   import dumpMapPkg::*;

   logic [wordWidth-1:0] sourceWord;
   logic [byteWidth-1:0] wordByte;

   ////////////////////////////////////////
   // Source word for the section
   ////////////////////////////////////////
   always_comb begin
      case (dumpSection)
         INSTR:   sourceWord = instr;
         REGS:    sourceWord = regFile[wordIndex*wordWidth +: wordWidth];
         MEM:     sourceWord = memData;   // Read through the debug address
         default: sourceWord = '0;
      endcase
   end

   // Most significant byte goes first
   assign wordByte = sourceWord[(bytesPerWord - 1 - byteIndex)*byteWidth +: byteWidth];

   // PC fits in one byte and skips the word path
   assign txData = (dumpSection == PC) ? byteWidth'(pc) : wordByte;

endmodule

`default_nettype wire

/* src/dumpMapPkg.sv */
`default_nettype none

package dumpMapPkg;

   ////////////////////////////////////////
   // Dump widths
   ////////////////////////////////////////
   localparam int byteWidth    = 8;
   localparam int wordWidth    = 32;
   localparam int bytesPerWord = wordWidth / byteWidth;
   localparam int pcWidth      = 8;    // PC goes out as a single byte

   // Dump sections, in the order they are sent
   typedef enum logic [1:0] {
      PC    = 2'd0,
      INSTR = 2'd1,
      REGS  = 2'd2,
      MEM   = 2'd3
   } dumpSection_t;

   // Total bytes in one dump
   function automatic int dumpLength(input int numRegs, input int numMemWords);
      int total;
      total = 1;                               // PC byte
      total = total + bytesPerWord;            // Fetched instruction
      total = total + bytesPerWord * numRegs;
      total = total + bytesPerWord * numMemWords;
      return total;
   endfunction

endpackage

`default_nettype wire

/* src/dumpSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module dumpSequencer #(
   parameter int numRegs     = 32,
   parameter int numMemWords = 16,
   localparam int indexWidth = (numRegs > 1) ? $clog2(numRegs) : 1,
   localparam int addrWidth  = (numMemWords > 1) ? $clog2(numMemWords) : 1
) (
   input  logic                             clock,
   input  logic                             reset,
   input  logic                             dumpStart,
   input  logic                             txDone,
   output logic                             txRequest,
   output logic                             dumpDone,
   output logic [dumpMapPkg::byteWidth-1:0] dumpCount,
   output dumpMapPkg::dumpSection_t         dumpSection,
   output logic [indexWidth-1:0]            wordIndex,
   output logic [1:0]                       byteIndex,
   output logic [addrWidth-1:0]             memAddr
);

   import dumpMapPkg::*;

   localparam logic [byteWidth-1:0]  lastCount = byteWidth'(dumpLength(numRegs, numMemWords) - 1);
   localparam logic [indexWidth-1:0] lastReg   = indexWidth'(numRegs - 1);
   localparam logic [1:0]            lastByte  = 2'(bytesPerWord - 1);

   logic dumpEnd;    // Transmitter took the final byte
   logic wordDone;   // Current byte is the least significant one

   assign dumpEnd  = txRequest && txDone && (dumpCount == lastCount);
   assign wordDone = (byteIndex == lastByte);

   ////////////////////////////////////////
   // Byte walk
   ////////////////////////////////////////
   always_ff @(posedge clock) begin
      if (reset) begin
         txRequest   <= 1'b0;
         dumpDone    <= 1'b0;
         dumpCount   <= '0;
         dumpSection <= PC;
         wordIndex   <= '0;
         byteIndex   <= '0;
      end else begin
         dumpDone <= dumpEnd;   // Strobe in the cycle after the last txDone

         if (dumpStart || dumpEnd) begin
            txRequest   <= dumpStart;   // Held until the last byte is taken
            dumpCount   <= '0;
            dumpSection <= PC;
            wordIndex   <= '0;
            byteIndex   <= '0;
         end else if (txRequest && txDone) begin
            dumpCount <= dumpCount + 1'b1;

            case (dumpSection)
               PC: begin
                  dumpSection <= INSTR;
                  byteIndex   <= '0;
               end

               INSTR: begin
                  byteIndex <= byteIndex + 1'b1;
                  if (wordDone) begin
                     dumpSection <= REGS;
                     wordIndex   <= '0;
                  end
               end

               REGS: begin
                  byteIndex <= byteIndex + 1'b1;
                  if (wordDone) begin
                     if (wordIndex == lastReg) begin
                        dumpSection <= MEM;   // Memory words restart at address 0
                        wordIndex   <= '0;
                     end else begin
                        wordIndex <= wordIndex + 1'b1;
                     end
                  end
               end

               MEM: begin
                  byteIndex <= byteIndex + 1'b1;
                  if (wordDone) begin
                     wordIndex <= wordIndex + 1'b1;
                  end
               end

               default: begin
                  dumpSection <= PC;
               end
            endcase
         end
      end
   end

   // Debug address follows the word being sent
   assign memAddr = (dumpSection == MEM) ? addrWidth'(wordIndex) : '0;

   // A request only opens right after the FSM asked for a dump
   txRequestInDump: assert property (
      @(posedge clock) disable iff (reset) $rose(txRequest) |-> $past(dumpStart));

   memAddrInRange: assert property (
      @(posedge clock) disable iff (reset) memAddr < numMemWords);

endmodule

`default_nettype wire

/* tb.f */
src/debugCmdPkg.sv
src/dumpMapPkg.sv
src/debugCommandFsm.sv
src/dumpSequencer.sv
src/dumpByteSelect.sv
src/debugUnit.sv
tb/debugUnitTb.sv

/* tb/debugGolden.mem */
// Words: pc, instr, 32 registers from r0, 16 memory words from address 0, script count
// Scripts: count, command bytes (first on top), endOfProgram cycle (ffffffff none), runs, dumps, idleLed
0000003c
8c220004
// Register file
00000000 0000000a 00000014 fffffff0
12345678 9abcdef0 00000100 7fffffff
80000000 0badf00d 00c0ffee 11223344
55667788 a5a5a5a5 5a5a5a5a 00000001
deadbeef cafebabe 0f0f0f0f f0f0f0f0
13579bdf 2468ace0 00ff00ff ff00ff00
01020304 05060708 090a0b0c 0d0e0f10
fedcba98 76543210 00000020 ffffffff
// Data memory
10000003 21000012 32000021 43000030
54000047 65000056 76000065 87000074
9800008b a900009a ba0000a9 cb0000b8
dc0000cf ed0000de fe0000ed 0f0000fc
// Scripts
00000005
00000001 78000000 ffffffff 00000000 00000000 00000001
00000003 736e6e00 ffffffff 00000002 00000002 00000000
00000001 63000000 0000001e 0000001d 00000001 00000001
00000003 736e6e00 00000014 00000001 00000001 00000001
00000003 7a736e00 ffffffff 00000001 00000001 00000000

/* tb/debugUnitTb.sv */
`timescale 1ns/1ps
`default_nettype none

module debugUnitTb;

   localparam int numRegs      = 32;
   localparam int numMemWords  = 16;
   localparam int addrWidth    = $clog2(numMemWords);
   localparam int regBase      = 2;                     // Golden index of register 0
   localparam int memBase      = regBase + numRegs;
   localparam int scriptBase   = memBase + numMemWords + 1;
   localparam int scriptWords  = 6;
   localparam int memFirstByte = 1 + 4 + 4 * numRegs;   // Dump position of memory word 0
   localparam int dumpBytes    = memFirstByte + 4 * numMemWords;
   localparam int byteCycles   = 13;                    // Longest UART delay plus handshake
   localparam logic [31:0] noEnd    = 32'hffff_ffff;
   localparam logic [7:0]  charCont = 8'h63;
   localparam logic [7:0]  charStep = 8'h73;

   logic                    clock;
   logic                    reset;
   logic [7:0]              rxByte;
   logic                    rxAvailable;
   logic                    rxPop;
   logic                    txDone;
   logic                    txRequest;
   logic [7:0]              txData;
   logic                    endOfProgram;
   logic [7:0]              pc;
   logic [31:0]             instr;
   logic [numRegs*32-1:0]   regFile;
   logic [31:0]             memData;
   logic                    datapathRun;
   logic                    datapathClear;
   logic                    memSelect;
   logic [addrWidth-1:0]    memAddr;
   logic                    idleLed;
   logic [7:0]              dumpCount;
   logic                    dumpDone;

   logic [31:0] golden [0:255];
   logic [7:0]  expectedDump [0:dumpBytes-1];
   logic [7:0]  fifoBytes [$];

   integer      seed = 28;
   int          errorCount = 0;
   int          checkCount = 0;
   int          cycleCount = 0;
   int          timeoutLimit = 0;
   int          resetLeft;
   int          scriptCycle;   // 0 is the INIT cycle after reset
   int          txWait;
   int          byteNum;       // Position in the current dump
   int          runCount;
   int          dumpsSeen;
   logic [31:0] eopCycle;
   logic        seenPop;
   logic        seenTxRequest;
   logic        seenIdle;
   logic        quiet;         // No command left and no dump running
   string       testName;

   debugUnit #(
      .numRegs     (numRegs),
      .numMemWords (numMemWords)
   ) uut (
      .clock         (clock),
      .reset         (reset),
      .rxByte        (rxByte),
      .rxAvailable   (rxAvailable),
      .rxPop         (rxPop),
      .txDone        (txDone),
      .txRequest     (txRequest),
      .txData        (txData),
      .endOfProgram  (endOfProgram),
      .pc            (pc),
      .instr         (instr),
      .regFile       (regFile),
      .memData       (memData),
      .datapathRun   (datapathRun),
      .datapathClear (datapathClear),
      .memSelect     (memSelect),
      .memAddr       (memAddr),
      .idleLed       (idleLed),
      .dumpCount     (dumpCount),
      .dumpDone      (dumpDone)
   );

   assign memData = golden[memBase + memAddr];   // Combinational data memory

   initial begin
      clock = 1'b0;
      forever #5 clock = ~clock;
   end

   always @(posedge clock) begin
      cycleCount = cycleCount + 1;
      if (cycleCount > timeoutLimit) begin
         $display("Timeout: the run did not finish within %0d cycles", timeoutLimit);
         $display("TEST FAILED");
         $finish;
      end
   end

   ////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////
   task automatic checkValue(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
      checkCount++;
      if (actual !== expected) begin
         errorCount++;
         $display("** Error %s: expected %0h, actual %0h", name, expected, actual);
      end
   endtask

   function automatic logic [7:0] msbFirstByte(input logic [31:0] word, input int position);
      return word[(3 - position) * 8 +: 8];
   endfunction

   function automatic int pickDelay();
      int rnd;
      rnd = $random(seed);
      if (rnd[1:0] == 2'b00) begin
         return 3 + rnd[6:4];   // Held back longer now and then
      end
      return 3;
   endfunction

   // PC byte, instruction, registers, memory, words MSB first
   task automatic buildExpected();
      int w;
      int b;
      expectedDump[0] = golden[0][7:0];
      for (b = 0; b < 4; b++) begin
         expectedDump[1 + b] = msbFirstByte(golden[1], b);
      end
      for (w = 0; w < numRegs; w++) begin
         for (b = 0; b < 4; b++) begin
            expectedDump[5 + 4 * w + b] = msbFirstByte(golden[regBase + w], b);
         end
      end
      for (w = 0; w < numMemWords; w++) begin
         for (b = 0; b < 4; b++) begin
            expectedDump[memFirstByte + 4 * w + b] = msbFirstByte(golden[memBase + w], b);
         end
      end
   endtask

   ////////////////////////////////////////
   // Sampling at the falling edge
   ////////////////////////////////////////
   task automatic sampleOutputs();
      logic  takeCommand;
      string name;
      seenPop       = rxPop && !reset;   // No pop is taken at a reset edge
      seenTxRequest = txRequest;
      seenIdle      = idleLed;
      quiet         = 1'b0;
      if (!reset && scriptCycle >= 0) begin
         if (scriptCycle == 0) begin
            checkValue({testName, " init rxPop"}, 0, rxPop);
            checkValue({testName, " init datapathRun"}, 0, datapathRun);
            checkValue({testName, " init txRequest"}, 0, txRequest);
            checkValue({testName, " init idleLed"}, 0, idleLed);
            checkValue({testName, " init datapathClear"}, 1, datapathClear);
         end
         if (scriptCycle == 1) checkValue({testName, " idleLed after init"}, 1, idleLed);
         if (idleLed) begin
            takeCommand = rxAvailable && (rxByte == charCont || rxByte == charStep);
            checkValue({testName, " idle datapathClear"}, !takeCommand, datapathClear);
            checkValue({testName, " idle rxPop"}, rxAvailable, rxPop);
         end else if (scriptCycle >= 1) begin
            checkValue({testName, " datapathClear outside idle"}, 0, datapathClear);
         end
         if (!memSelect) checkValue({testName, " txRequest outside dump"}, 0, txRequest);
         if (datapathRun) runCount++;
         if (txRequest && txDone) begin
            name = $sformatf("%s byte %0d", testName, byteNum);
            checkValue({name, " dumpCount"}, byteNum, dumpCount);
            checkValue({name, " memSelect"}, 1, memSelect);
            if (byteNum < dumpBytes) checkValue(name, expectedDump[byteNum], txData);
            if (byteNum >= memFirstByte) begin
               checkValue({name, " memAddr"}, (byteNum - memFirstByte) / 4, memAddr);
            end
            byteNum++;
         end
         if (dumpDone) begin
            dumpsSeen++;
            checkValue({testName, " dump length"}, dumpBytes, byteNum);
            byteNum = 0;
         end
         quiet = (scriptCycle >= 1) && !rxAvailable && !memSelect && !datapathRun;
      end
   endtask

   ////////////////////////////////////////
   // Driving 1 ns after the rising edge
   ////////////////////////////////////////
   task automatic driveInputs();
      logic [7:0] dropped;
      if (seenPop && fifoBytes.size() > 0) dropped = fifoBytes.pop_front();
      rxAvailable = (fifoBytes.size() > 0);
      rxByte      = rxAvailable ? fifoBytes[0] : 8'h00;

      if (resetLeft > 0) begin
         reset = 1'b1;
         resetLeft--;
      end else begin
         reset = 1'b0;
         scriptCycle++;
      end
      endOfProgram = (eopCycle != noEnd) && (scriptCycle >= 0) && (scriptCycle >= eopCycle);

      // UART transmitter model
      if (reset || txDone) begin
         txDone = 1'b0;
         txWait = -1;
      end else if (seenTxRequest) begin
         if (txWait < 0) txWait = pickDelay();
         if (txWait == 0) txDone = 1'b1;
         else txWait--;
      end
   endtask

   task automatic stepCycle();
      @(negedge clock);
      sampleOutputs();
      @(posedge clock);
      #1;
      driveInputs();
   endtask

   task automatic runScript(input int index);
      int          base;
      int          i;
      logic [31:0] cmdWord;
      base      = scriptBase + index * scriptWords;
      cmdWord   = golden[base + 1];
      eopCycle  = golden[base + 2];
      testName  = $sformatf("script%0d", index);
      fifoBytes.delete();
      for (i = 0; i < golden[base]; i++) begin
         fifoBytes.push_back(cmdWord[31 - 8 * i -: 8]);
      end
      runCount    = 0;
      dumpsSeen   = 0;
      byteNum     = 0;
      scriptCycle = -1;
      resetLeft   = 4;
      quiet       = 1'b0;
      while (!quiet) stepCycle();
      checkValue({testName, " run cycles"}, golden[base + 3], runCount);
      checkValue({testName, " dumps"}, golden[base + 4], dumpsSeen);
      checkValue({testName, " final idleLed"}, golden[base + 5], seenIdle);
   endtask

   ////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////
   initial begin
      int s;
      int r;
      int base;
      int total;
      int numScripts;
      $readmemh("tb/debugGolden.mem", golden);
      reset        = 1'b1;
      rxByte       = 8'h00;
      rxAvailable  = 1'b0;
      txDone       = 1'b0;
      endOfProgram = 1'b0;
      eopCycle     = noEnd;
      scriptCycle  = -1;
      resetLeft    = 0;
      txWait       = -1;
      pc           = golden[0][7:0];
      instr        = golden[1];
      for (r = 0; r < numRegs; r++) begin
         regFile[r * 32 +: 32] = golden[regBase + r];
      end
      buildExpected();

      numScripts = golden[memBase + numMemWords];
      total      = 0;
      for (s = 0; s < numScripts; s++) begin
         base  = scriptBase + s * scriptWords;
         total = total + 6 + golden[base] + golden[base + 4] * (dumpBytes * byteCycles + 4);
         if (golden[base + 2] != noEnd) total = total + golden[base + 2];
      end
      timeoutLimit = 4 * total;

      for (s = 0; s < numScripts; s++) runScript(s);

      $display("Checks: %0d, errors: %0d", checkCount, errorCount);
      if (errorCount == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
